// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv verif/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) compile.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f compile.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+verilog
+incdir+verif
verilog/cpu_pkg.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_exec.sv
verilog/cpu_bus_arbiter.sv
verilog/cpu_top.sv
verif/tb_cpu_top.sv

// ==== verif/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// One CMP and JRCC program, stores 1 when taken and 2 on fall-through
task automatic add_cond_prog(input int p, input string name, input logic [3:0] cond,
                             input logic [31:0] a, input logic [31:0] b, input bit taken);
  prog_name[p] = name;
  prog_code[p][0] = enc_ri(`OP_LD_W, 4'd2, 4'd0, 10'h100);
  prog_code[p][1] = enc_ri(`OP_LD_W, 4'd3, 4'd0, 10'h101);
  prog_code[p][2] = enc_ri(`OP_ADD, 4'd15, 4'd0, 10'h3F0);      // R15 = -16
  prog_code[p][3] = enc_rr(`OP_CMP, 4'd0, 4'd2, 4'd3);
  prog_code[p][4] = enc_ri(`OP_JRCC, cond, 4'd0, 10'd3);
  prog_code[p][5] = enc_ri(`OP_ADD, 4'd1, 4'd0, 10'd2);
  prog_code[p][6] = enc_jmp(16'd8);
  prog_code[p][7] = enc_ri(`OP_ADD, 4'd1, 4'd0, 10'd1);
  prog_code[p][8] = enc_ri(`OP_STO_W, 4'd1, 4'd15, 10'd0);
  prog_code[p][9] = enc_jmp(16'd9);
  prog_len[p] = 10;
  add_data(p, 24'h100, a);
  add_data(p, 24'h101, b);
  add_store(p, END_ADR, taken ? 32'd1 : 32'd2);
endtask

task automatic build_programs();
  // ALU and MOV
  prog_name[0] = "alu";
  prog_code[0][0]  = enc_mov(4'd1, 16'h1234);
  prog_code[0][1]  = enc_mov(4'd2, 16'h00F0);
  prog_code[0][2]  = enc_ri(`OP_ADD, 4'd15, 4'd0, 10'h3F0);
  prog_code[0][3]  = enc_rr(`OP_ADD, 4'd3, 4'd1, 4'd2);
  prog_code[0][4]  = enc_ri(`OP_STO_W, 4'd3, 4'd0, 10'h200);
  prog_code[0][5]  = enc_ri(`OP_SUB, 4'd4, 4'd2, 10'h3FD);      // Minus -3
  prog_code[0][6]  = enc_ri(`OP_STO_W, 4'd4, 4'd0, 10'h201);
  prog_code[0][7]  = enc_rr(`OP_AND, 4'd5, 4'd1, 4'd2);
  prog_code[0][8]  = enc_ri(`OP_OR, 4'd6, 4'd1, 10'h3FF);       // Logic immediate is unsigned
  prog_code[0][9]  = enc_rr(`OP_XOR, 4'd7, 4'd1, 4'd2);
  prog_code[0][10] = enc_ri(`OP_STO_W, 4'd5, 4'd0, 10'h202);
  prog_code[0][11] = enc_ri(`OP_STO_W, 4'd6, 4'd0, 10'h203);
  prog_code[0][12] = enc_ri(`OP_STO_W, 4'd7, 4'd0, 10'h204);
  prog_code[0][13] = enc_ri(`OP_ADD, 4'd8, 4'd0, 10'h3FB);
  prog_code[0][14] = enc_ri(`OP_STO_W, 4'd8, 4'd15, 10'd0);
  prog_code[0][15] = enc_jmp(16'd15);
  prog_len[0] = 16;
  add_store(0, 24'h200, 32'h0000_1324);
  add_store(0, 24'h201, 32'h0000_00F3);
  add_store(0, 24'h202, 32'h0000_0030);
  add_store(0, 24'h203, 32'h0000_13FF);
  add_store(0, 24'h204, 32'h0000_12C4);
  add_store(0, END_ADR, 32'hFFFF_FFFB);

  // Load, increment, store in a counted loop
  prog_name[1] = "load_store_loop";
  prog_code[1][0] = enc_ri(`OP_ADD, 4'd15, 4'd0, 10'h3F0);
  prog_code[1][1] = enc_ri(`OP_ADD, 4'd1, 4'd0, 10'd3);
  prog_code[1][2] = enc_ri(`OP_LD_W, 4'd2, 4'd0, 10'h100);
  prog_code[1][3] = enc_ri(`OP_ADD, 4'd2, 4'd2, 10'd1);
  prog_code[1][4] = enc_ri(`OP_STO_W, 4'd2, 4'd1, 10'h1FF);
  prog_code[1][5] = enc_ri(`OP_SUB, 4'd1, 4'd1, 10'd1);
  prog_code[1][6] = enc_ri(`OP_JRCC, `COND_NE, 4'd0, 10'h3FD);  // Back to 3
  prog_code[1][7] = enc_ri(`OP_LD_W, 4'd3, 4'd0, 10'h200);
  prog_code[1][8] = enc_ri(`OP_STO_W, 4'd3, 4'd15, 10'd0);
  prog_code[1][9] = enc_jmp(16'd9);
  prog_len[1] = 10;
  add_data(1, 24'h100, 32'h0000_FFFF);
  add_store(1, 24'h202, 32'h0001_0000);
  add_store(1, 24'h201, 32'h0001_0001);
  add_store(1, 24'h200, 32'h0001_0002);
  add_store(1, END_ADR, 32'h0001_0002);

  // Markers right behind taken jumps
  prog_name[2] = "flush";
  prog_code[2][0] = enc_ri(`OP_ADD, 4'd15, 4'd0, 10'h3F0);
  prog_code[2][1] = enc_ri(`OP_ADD, 4'd1, 4'd0, 10'h055);
  prog_code[2][2] = enc_jmp(16'd4);
  prog_code[2][3] = enc_ri(`OP_STO_W, 4'd1, 4'd0, 10'h300);
  prog_code[2][4] = enc_rr(`OP_CMP, 4'd0, 4'd0, 4'd0);
  prog_code[2][5] = enc_ri(`OP_JRCC, `COND_EQ, 4'd0, 10'd2);
  prog_code[2][6] = enc_ri(`OP_STO_W, 4'd1, 4'd0, 10'h301);
  prog_code[2][7] = enc_ri(`OP_STO_W, 4'd1, 4'd15, 10'd0);
  prog_code[2][8] = enc_jmp(16'd8);
  prog_len[2] = 9;
  add_store(2, END_ADR, 32'h0000_0055);

  //            index name   condition  a              b              taken
  add_cond_prog(3,  "eq", `COND_EQ, 32'd5,         32'd5,         1'b1);
  add_cond_prog(4,  "ne", `COND_NE, 32'd5,         32'd5,         1'b0);
  add_cond_prog(5,  "cs", `COND_CS, 32'd7,         32'd3,         1'b1);
  add_cond_prog(6,  "cc", `COND_CC, 32'd7,         32'd3,         1'b0);
  add_cond_prog(7,  "mi", `COND_MI, 32'd3,         32'd7,         1'b1);
  add_cond_prog(8,  "pl", `COND_PL, 32'd3,         32'd7,         1'b0);
  add_cond_prog(9,  "vs", `COND_VS, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 1'b1);
  add_cond_prog(10, "vc", `COND_VC, 32'd5,         32'd3,         1'b1);
  add_cond_prog(11, "hi", `COND_HI, 32'd3,         32'd7,         1'b0);
  add_cond_prog(12, "ls", `COND_LS, 32'd3,         32'd7,         1'b1);
  add_cond_prog(13, "ge", `COND_GE, 32'h8000_0000, 32'd1,         1'b0);
  add_cond_prog(14, "lt", `COND_LT, 32'h8000_0000, 32'd1,         1'b1);
  add_cond_prog(15, "gt", `COND_GT, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b1);
  add_cond_prog(16, "le", `COND_LE, 32'd5,         32'd5,         1'b1);
  add_cond_prog(17, "al", `COND_AL, 32'd1,         32'd9,         1'b1);
endtask

`endif

// ==== verif/tb_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu_top;

  localparam int          NPROG   = 18;
  localparam int          MAXST   = 8;
  localparam logic [23:0] END_ADR = 24'hFFFFF0;  // Every program ends with a store here
  localparam int          PERIOD  = 40;

  logic            i_clk;
  logic            i_rstb;
  logic            o_wb_cyc, o_wb_stb, o_wb_we;
  cpu_pkg::addr_t  o_wb_adr;
  cpu_pkg::data_t  o_wb_dat;
  cpu_pkg::data_t  i_wb_dat;
  logic            i_wb_ack;

  // Program table, filled by build_programs
  string       prog_name [NPROG];
  logic [23:0] prog_code [NPROG][16];
  int          prog_len  [NPROG];
  logic [23:0] data_adr  [NPROG][2];
  logic [31:0] data_val  [NPROG][2];
  int          data_n    [NPROG];
  logic [23:0] exp_adr   [NPROG][MAXST];
  logic [31:0] exp_dat   [NPROG][MAXST];
  int          exp_n     [NPROG];

  logic [31:0] mem [logic [23:0]];
  logic [23:0] wr_adr [$];
  logic [31:0] wr_dat [$];
  logic [31:0] rng;
  int          wait_left;
  bit          end_seen;
  int          errors;
  int          tests_failed;

  cpu_top i_dut (
    .i_clk(i_clk), .i_rstb(i_rstb),
    .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
    .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack));

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Assemblers for the instruction formats
  function automatic logic [23:0] enc_rr(input logic [4:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs0, input logic [3:0] rs1);
    return {op, 1'b0, 2'b00, rd, rs0, rs1, 4'h0};
  endfunction

  function automatic logic [23:0] enc_ri(input logic [4:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs0, input logic [9:0] imm);
    return {op, 1'b1, imm[5:4], rd, rs0, imm[9:6], imm[3:0]};
  endfunction

  function automatic logic [23:0] enc_mov(input logic [3:0] rd, input logic [15:0] imm);
    return {4'b0110, imm[15:14], imm[5:4], rd, imm[13:10], imm[9:6], imm[3:0]};
  endfunction

  function automatic logic [23:0] enc_jmp(input logic [15:0] target);
    return {`OP_JMP, 1'b1, 2'b00, target};
  endfunction

  task automatic add_data(input int p, input logic [23:0] adr, input logic [31:0] val);
    data_adr[p][data_n[p]] = adr;
    data_val[p][data_n[p]] = val;
    data_n[p]++;
  endtask

  task automatic add_store(input int p, input logic [23:0] adr, input logic [31:0] val);
    exp_adr[p][exp_n[p]] = adr;
    exp_dat[p][exp_n[p]] = val;
    exp_n[p]++;
  endtask

  `include "tb_programs.svh"

  always #(PERIOD / 2) i_clk = ~i_clk;

  // Wishbone slave memory with 0 to 3 wait states
  always @(negedge i_clk) begin
    if (!i_rstb || i_wb_ack) begin
      i_wb_ack <= 1'b0;                  // Single-cycle ack
    end else if (o_wb_cyc && o_wb_stb) begin
      if (wait_left > 0) begin
        wait_left <= wait_left - 1;
      end else begin
        if (o_wb_we) begin
          mem[o_wb_adr] = o_wb_dat;
          wr_adr.push_back(o_wb_adr);
          wr_dat.push_back(o_wb_dat);
          if (o_wb_adr == END_ADR) end_seen = 1'b1;
        end else begin
          i_wb_dat <= mem.exists(o_wb_adr) ? mem[o_wb_adr] : {8'hA5, o_wb_adr};
        end
        i_wb_ack  <= 1'b1;
        rng       = xorshift(rng);
        wait_left <= int'(rng[1:0]);
      end
    end
  end

  task automatic check_stores(input int p);
    int n;
    n = wr_adr.size();
    if (n != exp_n[p]) begin
      $display("CHECK FAILED at %0d ns: %s made %0d stores, expected %0d",
               $time, prog_name[p], n, exp_n[p]);
      errors++;
    end
    for (int k = 0; k < n && k < exp_n[p]; k++) begin
      if (wr_adr[k] != exp_adr[p][k] || wr_dat[k] != exp_dat[p][k]) begin
        $display("CHECK FAILED at %0d ns: %s store %0d wrote %h to %h, expected %h to %h",
                 $time, prog_name[p], k, wr_dat[k], wr_adr[k], exp_dat[p][k], exp_adr[p][k]);
        errors++;
      end
    end
  endtask

  initial begin
    int errs_before;
    i_clk = 1'b0;
    i_rstb <= 1'b0;
    i_wb_ack <= 1'b0;
    i_wb_dat <= '0;
    rng = 32'd62835;
    wait_left <= 0;
    errors = 0;
    tests_failed = 0;
    for (int p = 0; p < NPROG; p++) begin
      data_n[p] = 0;
      exp_n[p] = 0;
    end
    build_programs();
    for (int p = 0; p < NPROG; p++) begin
      @(negedge i_clk);
      errs_before = errors;
      i_rstb <= 1'b0;
      mem.delete();
      wr_adr.delete();
      wr_dat.delete();
      end_seen = 1'b0;
      for (int i = 0; i < prog_len[p]; i++) mem[24'(i)] = {8'h00, prog_code[p][i]};
      for (int k = 0; k < data_n[p]; k++) mem[data_adr[p][k]] = data_val[p][k];
      repeat (10) @(negedge i_clk);
      if (o_wb_cyc || o_wb_stb || o_wb_we) begin
        $display("CHECK FAILED at %0d ns: %s bus is not idle in reset", $time, prog_name[p]);
        errors++;
      end
      i_rstb <= 1'b1;
      @(negedge i_clk);
      // First cycle after reset is an instruction read from address 0
      if (!o_wb_cyc || !o_wb_stb || o_wb_we || o_wb_adr != 24'h0) begin
        $display("CHECK FAILED at %0d ns: %s first bus cycle is not a fetch from 0",
                 $time, prog_name[p]);
        errors++;
      end
      while (!end_seen) @(negedge i_clk);
      repeat (4) @(negedge i_clk);       // Nothing may follow the end store
      check_stores(p);
      if (errors == errs_before) begin
        $display("test %0d %s: ok", p, prog_name[p]);
      end else begin
        $display("test %0d %s: failed", p, prog_name[p]);
        tests_failed++;
      end
    end
    $display("%0d tests, %0d failed, %0d check errors", NPROG, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the program count
  initial begin
    #((400 + 20) * NPROG * PERIOD);
    $display("Timeout: the programs did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_alu (
  input  wire cpu_pkg::opcode_t i_opcode,
  input  wire cpu_pkg::data_t   i_a,
  input  wire cpu_pkg::data_t   i_b,
  output cpu_pkg::data_t        o_result,
  output cpu_pkg::flags_t       o_flags
);

  localparam int MSB = `CPU_DATA_W - 1;

  logic [`CPU_DATA_W:0] sum;     // Carry out in the top bit
  logic                 carry;
  logic                 ovf;

  always_comb begin
    sum      = '0;
    carry    = 1'b0;
    ovf      = 1'b0;
    o_result = i_b;              // MOV passes operand b
    case (i_opcode)
      `OP_ADD: begin
        sum      = {1'b0, i_a} + {1'b0, i_b};
        o_result = sum[MSB:0];
        carry    = sum[`CPU_DATA_W];
        ovf      = (i_a[MSB] == i_b[MSB]) && (o_result[MSB] != i_a[MSB]);
      end
      `OP_SUB, `OP_CMP: begin
        sum      = {1'b0, i_a} + {1'b0, ~i_b} + 1'b1;
        o_result = sum[MSB:0];
        carry    = sum[`CPU_DATA_W];     // Set when no borrow
        ovf      = (i_a[MSB] != i_b[MSB]) && (o_result[MSB] != i_a[MSB]);
      end
      `OP_AND: o_result = i_a & i_b;
      `OP_OR:  o_result = i_a | i_b;
      `OP_XOR: o_result = i_a ^ i_b;
      default: o_result = i_b;
    endcase
    o_flags          = '0;
    o_flags[`FLAG_Z] = (o_result == '0);
    o_flags[`FLAG_S] = o_result[MSB];
    o_flags[`FLAG_C] = carry;
    o_flags[`FLAG_V] = ovf;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_arbiter (
  input  wire                  i_clk,
  input  wire                  i_rstb,
  input  wire                  i_f_cyc,
  input  wire                  i_f_stb,
  input  wire cpu_pkg::addr_t  i_f_adr,
  output cpu_pkg::data_t       o_f_dat,
  output logic                 o_f_ack,
  input  wire                  i_e_cyc,
  input  wire                  i_e_stb,
  input  wire                  i_e_we,
  input  wire cpu_pkg::addr_t  i_e_adr,
  input  wire cpu_pkg::data_t  i_e_dat,
  output cpu_pkg::data_t       o_e_dat,
  output logic                 o_e_ack,
  output logic                 o_wb_cyc,
  output logic                 o_wb_stb,
  output logic                 o_wb_we,
  output cpu_pkg::addr_t       o_wb_adr,
  output cpu_pkg::data_t       o_wb_dat,
  input  wire cpu_pkg::data_t  i_wb_dat,
  input  wire                  i_wb_ack
);

  logic [1:0] grant_q;       // Bit 1 execute, bit 0 fetch
  logic [1:0] grant;
  logic       locked;

  // Owner keeps the bus until it drops cyc, otherwise execute wins
  assign locked = (grant_q[1] && i_e_cyc) || (grant_q[0] && i_f_cyc);

  always_comb begin
    if (locked) begin
      grant = grant_q;
    end else if (i_e_cyc) begin
      grant = 2'b10;
    end else if (i_f_cyc) begin
      grant = 2'b01;
    end else begin
      grant = 2'b00;
    end
  end

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) grant_q <= 2'b00;
    else         grant_q <= grant;
  end

  assign o_wb_cyc = |grant;                              // A grant implies cyc
  assign o_wb_stb = grant[1] ? i_e_stb : (grant[0] && i_f_stb);
  assign o_wb_we  = grant[1] && i_e_we;                  // Fetch only reads
  assign o_wb_adr = grant[1] ? i_e_adr : i_f_adr;
  assign o_wb_dat = i_e_dat;
  assign o_f_ack  = grant[0] && i_wb_ack;
  assign o_e_ack  = grant[1] && i_wb_ack;
  assign o_f_dat  = grant[0] ? i_wb_dat : '0;
  assign o_e_dat  = grant[1] ? i_wb_dat : '0;

  // An unacked transfer keeps its owner and its request
  a_grant_hold: assert property (@(posedge i_clk) disable iff (!i_rstb)
    o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(grant) && $stable(o_wb_adr) &&
                              $stable(o_wb_we));

endmodule

`default_nettype wire

// ==== verilog/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_decode (
  input  wire cpu_pkg::instr_t i_instr,
  output cpu_pkg::opcode_t     o_opcode,
  output cpu_pkg::reg_idx_t    o_rd,
  output cpu_pkg::reg_idx_t    o_rs0,
  output cpu_pkg::reg_idx_t    o_rs1,
  output cpu_pkg::data_t       o_imm,
  output logic                 o_use_imm,
  output cpu_pkg::cond_t       o_cond,
  output logic                 o_rf_wr,
  output logic                 o_flags_wr
);

  logic [9:0]  imm10;
  logic [15:0] imm16_mov;
  logic [15:0] imm16_jmp;

  assign imm10 = {i_instr[`CPU_F_RS1], i_instr[`CPU_F_IMM_MID], i_instr[`CPU_F_IMM_LO]};
  assign imm16_mov = {i_instr[`CPU_F_MOV_HI], i_instr[`CPU_F_RS0], i_instr[`CPU_F_RS1],
                      i_instr[`CPU_F_IMM_MID], i_instr[`CPU_F_IMM_LO]};
  assign imm16_jmp = {i_instr[`CPU_F_RD], i_instr[`CPU_F_RS0], i_instr[`CPU_F_RS1],
                      i_instr[`CPU_F_IMM_LO]};

  always_comb begin
    o_opcode   = i_instr[`CPU_F_OPC];
    o_rd       = i_instr[`CPU_F_RD];
    o_rs0      = i_instr[`CPU_F_RS0];
    o_rs1      = i_instr[`CPU_F_IMMF] ? '0 : i_instr[`CPU_F_RS1];
    o_imm      = cpu_pkg::data_t'(imm10);            // Zero extended by default
    o_use_imm  = i_instr[`CPU_F_IMMF];
    o_cond     = `COND_AL;
    o_rf_wr    = 1'b0;
    o_flags_wr = 1'b0;
    if ((o_opcode | 5'b00001) == (`OP_MOV | 5'b00001)) o_opcode = `OP_MOV;
    case (o_opcode)
      `OP_ADD, `OP_SUB, `OP_CMP: begin
        o_imm      = cpu_pkg::data_t'($signed(imm10));
        o_rf_wr    = (o_opcode != `OP_CMP);
        o_flags_wr = 1'b1;
      end
      `OP_AND, `OP_OR, `OP_XOR: begin
        o_rf_wr    = 1'b1;
        o_flags_wr = 1'b1;
      end
      `OP_MOV: begin
        o_imm     = cpu_pkg::data_t'(imm16_mov);
        o_use_imm = 1'b1;
        o_rs0     = '0;
        o_rs1     = '0;
        o_rf_wr   = 1'b1;
      end
      `OP_LD_W: begin
        o_use_imm = 1'b1;                               // Address is rs0 + imm
        o_rs1     = '0;
        o_rf_wr   = 1'b1;
      end
      `OP_STO_W: begin
        o_use_imm = 1'b1;
        o_rs1     = i_instr[`CPU_F_RD];                 // Store data on read port 1
        o_rd      = '0;
      end
      `OP_JMP, `OP_JRCC: begin
        o_imm     = (o_opcode == `OP_JMP) ? cpu_pkg::data_t'(imm16_jmp)
                                          : cpu_pkg::data_t'($signed(imm10));
        o_cond    = (o_opcode == `OP_JMP) ? `COND_AL : i_instr[`CPU_F_RD];
        o_use_imm = 1'b1;
        o_rd      = '0;
        o_rs0     = '0;
        o_rs1     = '0;
      end
      default: begin                                    // Unknown opcode runs as a no-op
        o_rd  = '0;
        o_rs0 = '0;
        o_rs1 = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Widths
`define CPU_INSTR_W   24
`define CPU_DATA_W    32
`define CPU_ADDR_W    24            // Word address
`define CPU_REG_AW    4

// Instruction fields
`define CPU_F_OPC     23:19
`define CPU_F_IMMF    18            // Operand b from immediate
`define CPU_F_IMM_MID 17:16
`define CPU_F_RD      15:12         // Also condition code of JRCC
`define CPU_F_RS0     11:8
`define CPU_F_RS1     7:4           // Or immediate high nibble
`define CPU_F_IMM_LO  3:0
`define CPU_F_MOV_HI  19:18         // Top of the MOV immediate

// Opcodes
`define OP_LD_W       5'b00010
`define OP_STO_W      5'b00110
`define OP_JMP        5'b01000
`define OP_JRCC       5'b01010
`define OP_MOV        5'b01100      // Low opcode bit is immediate data
`define OP_ADD        5'b10000
`define OP_SUB        5'b10001
`define OP_AND        5'b10010
`define OP_OR         5'b10011
`define OP_XOR        5'b10100
`define OP_CMP        5'b10101

// Jump conditions
`define COND_EQ       4'h0
`define COND_NE       4'h1
`define COND_CS       4'h2
`define COND_CC       4'h3
`define COND_MI       4'h4
`define COND_PL       4'h5
`define COND_VS       4'h6
`define COND_VC       4'h7
`define COND_HI       4'h8
`define COND_LS       4'h9
`define COND_GE       4'hA
`define COND_LT       4'hB
`define COND_GT       4'hC
`define COND_LE       4'hD
`define COND_AL       4'hF

// Flag bit positions
`define FLAG_Z        3
`define FLAG_S        2
`define FLAG_C        1
`define FLAG_V        0

`endif

// ==== verilog/cpu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_exec (
  input  wire                  i_clk,
  input  wire                  i_rstb,
  input  wire cpu_pkg::instr_t i_instr,
  input  wire cpu_pkg::addr_t  i_instr_pc,
  input  wire                  i_instr_valid,
  output logic                 o_instr_take,
  output logic                 o_redirect,
  output cpu_pkg::addr_t       o_redirect_pc,
  output logic                 o_cyc,
  output logic                 o_stb,
  output logic                 o_we,
  output cpu_pkg::addr_t       o_adr,
  output cpu_pkg::data_t       o_dat,
  input  wire cpu_pkg::data_t  i_dat,
  input  wire                  i_ack
);

  cpu_pkg::exec_state_t state, state_nxt;
  cpu_pkg::instr_t      ir;                // Instruction being executed
  cpu_pkg::addr_t       ir_pc;
  cpu_pkg::flags_t      flags_q, alu_flags;
  cpu_pkg::opcode_t     opcode;
  cpu_pkg::reg_idx_t    rd, rs0, rs1;
  cpu_pkg::data_t       imm, rf_dout_0, rf_dout_1, alu_b, alu_result, rf_din;
  cpu_pkg::cond_t       cond;
  logic use_imm, rf_wr, flags_wr, rf_we, is_load, is_store, cond_ok, jump_taken;

  cpu_decode u_decode (.i_instr(ir), .o_opcode(opcode), .o_rd(rd), .o_rs0(rs0), .o_rs1(rs1),
                       .o_imm(imm), .o_use_imm(use_imm), .o_cond(cond), .o_rf_wr(rf_wr),
                       .o_flags_wr(flags_wr));

  cpu_regfile u_regfile (.i_clk(i_clk), .i_rstb(i_rstb), .i_we(rf_we), .i_waddr(rd),
                         .i_raddr_0(rs0), .i_raddr_1(rs1), .i_din(rf_din),
                         .o_dout_0(rf_dout_0), .o_dout_1(rf_dout_1));

  cpu_alu u_alu (.i_opcode(opcode), .i_a(rf_dout_0), .i_b(alu_b), .o_result(alu_result),
                 .o_flags(alu_flags));

  assign is_load    = (opcode == `OP_LD_W);
  assign is_store   = (opcode == `OP_STO_W);
  assign alu_b      = use_imm ? imm : rf_dout_1;
  assign jump_taken = (opcode == `OP_JMP) || (opcode == `OP_JRCC && cond_ok);
  assign rf_we      = rf_wr && ((state == cpu_pkg::EX_RUN && !is_load) ||
                                (state == cpu_pkg::EX_MEM && i_ack));
  assign rf_din     = is_load ? i_dat : alu_result;

  assign o_instr_take  = (state == cpu_pkg::EX_WAIT) && i_instr_valid;
  assign o_redirect    = (state == cpu_pkg::EX_JUMP);
  assign o_redirect_pc = (opcode == `OP_JRCC) ? cpu_pkg::addr_t'(ir_pc + imm)  // Relative
                                              : cpu_pkg::addr_t'(imm);
  assign o_cyc = (state == cpu_pkg::EX_MEM);
  assign o_stb = o_cyc;
  assign o_we  = o_cyc && is_store;
  assign o_adr = cpu_pkg::addr_t'(rf_dout_0 + imm);   // Base plus offset
  assign o_dat = rf_dout_1;

  // Condition table on the stored flags
  always_comb begin
    case (cond)
      `COND_EQ: cond_ok = flags_q[`FLAG_Z];
      `COND_NE: cond_ok = !flags_q[`FLAG_Z];
      `COND_CS: cond_ok = flags_q[`FLAG_C];
      `COND_CC: cond_ok = !flags_q[`FLAG_C];
      `COND_MI: cond_ok = flags_q[`FLAG_S];
      `COND_PL: cond_ok = !flags_q[`FLAG_S];
      `COND_VS: cond_ok = flags_q[`FLAG_V];
      `COND_VC: cond_ok = !flags_q[`FLAG_V];
      `COND_HI: cond_ok = flags_q[`FLAG_C] && !flags_q[`FLAG_Z];
      `COND_LS: cond_ok = !flags_q[`FLAG_C] || flags_q[`FLAG_Z];
      `COND_GE: cond_ok = (flags_q[`FLAG_S] == flags_q[`FLAG_V]);
      `COND_LT: cond_ok = (flags_q[`FLAG_S] != flags_q[`FLAG_V]);
      `COND_GT: cond_ok = !flags_q[`FLAG_Z] && (flags_q[`FLAG_S] == flags_q[`FLAG_V]);
      `COND_LE: cond_ok = flags_q[`FLAG_Z] || (flags_q[`FLAG_S] != flags_q[`FLAG_V]);
      default:  cond_ok = 1'b1;               // Always
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      cpu_pkg::EX_WAIT: if (i_instr_valid) state_nxt = cpu_pkg::EX_RUN;
      cpu_pkg::EX_RUN: begin
        if (is_load || is_store) state_nxt = cpu_pkg::EX_MEM;
        else if (jump_taken)     state_nxt = cpu_pkg::EX_JUMP;
        else                     state_nxt = cpu_pkg::EX_WAIT;
      end
      cpu_pkg::EX_MEM:  if (i_ack) state_nxt = cpu_pkg::EX_WAIT;
      default:          state_nxt = cpu_pkg::EX_WAIT;   // EX_JUMP lasts one cycle
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      state   <= cpu_pkg::EX_WAIT;
      flags_q <= '0;
    end else begin
      state <= state_nxt;
      if (state == cpu_pkg::EX_RUN && flags_wr) flags_q <= alu_flags;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_instr_take) begin
      ir    <= i_instr;
      ir_pc <= i_instr_pc;
    end
  end

  // A redirect belongs to a jump whose condition still holds on the stored flags
  a_redirect_src: assert property (@(posedge i_clk) disable iff (!i_rstb)
    o_redirect |-> jump_taken);

endmodule

`default_nettype wire

// ==== verilog/cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_fetch (
  input  wire                  i_clk,
  input  wire                  i_rstb,
  output cpu_pkg::instr_t      o_instr,
  output cpu_pkg::addr_t       o_instr_pc,
  output logic                 o_instr_valid,
  input  wire                  i_instr_take,
  input  wire                  i_redirect,
  input  wire cpu_pkg::addr_t  i_redirect_pc,
  output logic                 o_cyc,
  output logic                 o_stb,
  output cpu_pkg::addr_t       o_adr,
  input  wire cpu_pkg::data_t  i_dat,
  input  wire                  i_ack
);

  cpu_pkg::fetch_state_t state;
  cpu_pkg::addr_t        pc;          // Address of the next fetch
  cpu_pkg::instr_t       buf_instr;
  cpu_pkg::addr_t        buf_pc;
  logic                  flush;       // Word in flight is stale

  assign o_instr       = buf_instr;
  assign o_instr_pc    = buf_pc;
  assign o_instr_valid = (state == cpu_pkg::FE_FULL);
  assign o_cyc         = (state == cpu_pkg::FE_BUS);
  assign o_stb         = o_cyc;
  assign o_adr         = pc;

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      state <= cpu_pkg::FE_IDLE;
      pc    <= '0;
      flush <= 1'b0;
    end else begin
      case (state)
        cpu_pkg::FE_IDLE: begin
          state <= cpu_pkg::FE_BUS;
          if (i_redirect) pc <= i_redirect_pc;
        end
        cpu_pkg::FE_BUS: begin
          if (i_ack) begin
            flush <= 1'b0;
            if (i_redirect) begin
              pc    <= i_redirect_pc;
              state <= cpu_pkg::FE_IDLE;
            end else if (flush) begin
              pc    <= buf_pc;              // Parked jump target
              state <= cpu_pkg::FE_IDLE;
            end else begin
              pc    <= pc + 1'b1;
              state <= cpu_pkg::FE_FULL;
            end
          end else if (i_redirect) begin
            flush <= 1'b1;                  // Finish the cycle, drop the word
          end
        end
        cpu_pkg::FE_FULL: begin
          if (i_redirect) begin
            pc    <= i_redirect_pc;
            state <= cpu_pkg::FE_BUS;
          end else if (i_instr_take) begin
            state <= cpu_pkg::FE_BUS;       // Buffer free again, fetch ahead
          end
        end
        default: state <= cpu_pkg::FE_IDLE;
      endcase
    end
  end

  // Buffer is empty during a bus cycle, so buf_pc can hold a pending target
  always_ff @(posedge i_clk) begin
    if (state == cpu_pkg::FE_BUS && i_ack) begin
      buf_instr <= i_dat[`CPU_INSTR_W-1:0];
      buf_pc    <= pc;
    end else if (state == cpu_pkg::FE_BUS && i_redirect) begin
      buf_pc    <= i_redirect_pc;
    end
  end

  // Request held with a stable address until acked
  a_stb_hold: assert property (@(posedge i_clk) disable iff (!i_rstb)
    o_stb && !i_ack |=> o_stb && $stable(o_adr));

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none
`include "cpu_defines.svh"

package cpu_pkg;

  typedef logic [`CPU_INSTR_W-1:0] instr_t;
  typedef logic [`CPU_DATA_W-1:0]  data_t;
  typedef logic [`CPU_ADDR_W-1:0]  addr_t;
  typedef logic [`CPU_REG_AW-1:0]  reg_idx_t;
  typedef logic [4:0]              opcode_t;
  typedef logic [3:0]              cond_t;
  typedef logic [3:0]              flags_t;     // Z S C V

  // Execute unit sequencing
  typedef enum logic [1:0] {EX_WAIT, EX_RUN, EX_MEM, EX_JUMP} exec_state_t;

  // Prefetch buffer state
  typedef enum logic [1:0] {FE_IDLE, FE_BUS, FE_FULL} fetch_state_t;

endpackage

`default_nettype wire

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_regfile (
  input  wire                    i_clk,
  input  wire                    i_rstb,
  input  wire                    i_we,
  input  wire cpu_pkg::reg_idx_t i_waddr,
  input  wire cpu_pkg::reg_idx_t i_raddr_0,
  input  wire cpu_pkg::reg_idx_t i_raddr_1,
  input  wire cpu_pkg::data_t    i_din,
  output cpu_pkg::data_t         o_dout_0,
  output cpu_pkg::data_t         o_dout_1
);

  cpu_pkg::data_t regs [1 << `CPU_REG_AW];

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      for (int i = 0; i < (1 << `CPU_REG_AW); i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin    // R0 never written
      regs[i_waddr] <= i_din;
    end
  end

  // R0 holds its reset value of zero
  assign o_dout_0 = regs[i_raddr_0];
  assign o_dout_1 = regs[i_raddr_1];

endmodule

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire                  i_clk,
  input  wire                  i_rstb,
  output wire                  o_wb_cyc,
  output wire                  o_wb_stb,
  output wire                  o_wb_we,
  output wire cpu_pkg::addr_t  o_wb_adr,
  output wire cpu_pkg::data_t  o_wb_dat,
  input  wire cpu_pkg::data_t  i_wb_dat,
  input  wire                  i_wb_ack
);

  cpu_pkg::instr_t instr;
  cpu_pkg::addr_t  instr_pc, redirect_pc, f_adr, e_adr;
  cpu_pkg::data_t  f_dat, e_dat_rd, e_dat_wr;
  logic            instr_valid, instr_take, redirect;
  logic            f_cyc, f_stb, f_ack;
  logic            e_cyc, e_stb, e_we, e_ack;

  // Instruction prefetch master
  cpu_fetch u_fetch (
    .i_clk(i_clk), .i_rstb(i_rstb),
    .o_instr(instr), .o_instr_pc(instr_pc), .o_instr_valid(instr_valid),
    .i_instr_take(instr_take), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .o_cyc(f_cyc), .o_stb(f_stb), .o_adr(f_adr), .i_dat(f_dat), .i_ack(f_ack));

  // Execute unit, also the load/store master
  cpu_exec u_exec (
    .i_clk(i_clk), .i_rstb(i_rstb),
    .i_instr(instr), .i_instr_pc(instr_pc), .i_instr_valid(instr_valid),
    .o_instr_take(instr_take), .o_redirect(redirect), .o_redirect_pc(redirect_pc),
    .o_cyc(e_cyc), .o_stb(e_stb), .o_we(e_we), .o_adr(e_adr), .o_dat(e_dat_wr),
    .i_dat(e_dat_rd), .i_ack(e_ack));

  cpu_bus_arbiter u_arb (
    .i_clk(i_clk), .i_rstb(i_rstb),
    .i_f_cyc(f_cyc), .i_f_stb(f_stb), .i_f_adr(f_adr), .o_f_dat(f_dat), .o_f_ack(f_ack),
    .i_e_cyc(e_cyc), .i_e_stb(e_stb), .i_e_we(e_we), .i_e_adr(e_adr), .i_e_dat(e_dat_wr),
    .o_e_dat(e_dat_rd), .o_e_ack(e_ack),
    .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we), .o_wb_adr(o_wb_adr),
    .o_wb_dat(o_wb_dat), .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack));

endmodule

`default_nettype wire
